//--- design/fcuIsaPkg.sv
/*
  Instruction encoding for the flow-control unit
  Opcode and function field types with their values
  Field positions within the 40-bit instruction word
  Operating-level codes
*/
package fcuIsaPkg;

  // ====================================================================
  // Field types and positions
  // ====================================================================
  typedef logic [3:0] opcodeT;
  typedef logic [4:0] functT;

  // Opcode at bits 9..6
  localparam int opcodeLsb = 6;
  // Function field at bits 27..23, only meaningful under BMISC
  localparam int functLsb = 23;
  // RET immediate spans bits 39..22
  localparam int immLsb = 22;
  localparam int immWidth = 18;
  // BRK cause shares the immediate base, bits 29..22
  localparam int causeWidth = 8;

  // ====================================================================
  // Opcode and function values
  // ====================================================================
  localparam opcodeT opBrk = 4'd0;
  localparam opcodeT opJal = 4'd1;
  localparam opcodeT opCall = 4'd2;
  localparam opcodeT opRet = 4'd3;
  localparam opcodeT opRex = 4'd4;
  localparam opcodeT opBmisc = 4'd5;

  localparam functT fnRti = 5'd8;
  localparam functT fnWait = 5'd9;

  // Operating levels, machine is most privileged
  localparam logic [1:0] olMachine = 2'd0;
  localparam logic [1:0] olSuper = 2'd1;
  localparam logic [1:0] olHyper = 2'd2;
  localparam logic [1:0] olUser = 2'd3;

endpackage

//--- design/fcuTypesPkg.sv
/*
  Shared types for the flow-control unit
  Vector typedefs for instruction, level and interrupt mask
  Decoded operation kind
  Poison nibble used for illegal results
*/
package fcuTypesPkg;

  // ====================================================================
  // Plain vector types
  // ====================================================================
  // Full instruction word
  typedef logic [39:0] instrT;

  // Operating level, 0 is most privileged
  typedef logic [1:0] olT;

  // Interrupt mask level
  typedef logic [3:0] imT;

  // ====================================================================
  // Decoded operation
  // ====================================================================
  // JAL and CALL share kLink
  // RTI and unknown encodings land in kIllegal
  typedef enum logic [2:0] {
    kBrk,
    kLink,
    kRet,
    kRex,
    kWait,
    kIllegal
  } opKindT;

  // Repeated across the result word for anything that faults
  localparam logic [3:0] poisonNibble = 4'hC;

endpackage

//--- design/fcuIssue.sv
/*
  Issue stage of the flow-control unit
  Captures an issued instruction and its operands
  Decodes opcode and function field into an operation kind
*/
`timescale 1ns/1ns

module fcuIssue
  import fcuIsaPkg::*;
  import fcuTypesPkg::*;
#(
  parameter int dataWidth = 80,
  parameter int addrWidth = 80
)
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 issue,
  input  olT                   ol,
  input  instrT                instr,
  input  logic [dataWidth-1:0] tvec,
  input  logic [dataWidth-1:0] a,
  input  logic [addrWidth-1:0] nextPc,
  input  imT                   im,
  input  logic [dataWidth-1:0] waitCtr,
  output logic                 calcValid,
  output opKindT               opKind,
  output olT                   olQ,
  output instrT                instrQ,
  output logic [dataWidth-1:0] tvecQ,
  output logic [dataWidth-1:0] aQ,
  output logic [addrWidth-1:0] nextPcQ,
  output imT                   imQ,
  output logic [dataWidth-1:0] waitCtrQ
);

  opcodeT opcode;
  functT funct;
  opKindT decodedKind;

  // Field extraction from the incoming word
  assign opcode = instr[opcodeLsb +: $bits(opcodeT)];
  assign funct = instr[functLsb +: $bits(functT)];

  // ====================================================================
  // Decode
  // ====================================================================
  always_comb
  begin
    case (opcode)
      opBrk: decodedKind = kBrk;
      // Both link forms just need nextPc
      opJal, opCall: decodedKind = kLink;
      opRet: decodedKind = kRet;
      opRex: decodedKind = kRex;
      opBmisc:
        case (funct)
          fnWait: decodedKind = kWait;
          // RTI is not supported by this unit
          fnRti: decodedKind = kIllegal;
          default: decodedKind = kIllegal;
        endcase
      default: decodedKind = kIllegal;
    endcase
  end

  // Strobe for the calculator, one cycle after issue
  always_ff @(posedge clk)
  begin
    if (!rstN)
      calcValid <= 1'b0;
    else
      calcValid <= issue;
  end

  // Operand capture, held until the next issue
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      opKind <= decodedKind;
      olQ <= ol;
      instrQ <= instr;
      tvecQ <= tvec;
      aQ <= a;
      nextPcQ <= nextPc;
      imQ <= im;
      waitCtrQ <= waitCtr;
    end
  end

endmodule

//--- design/fcuCalc.sv
/*
  Flow-control result calculator
  Combinational result per operation kind
  REX trap-vector decision and poison word
*/
`timescale 1ns/1ns

module fcuCalc
  import fcuIsaPkg::*;
  import fcuTypesPkg::*;
#(
  parameter int dataWidth = 80,
  parameter int addrWidth = 80
)
(
  input  logic                 calcValid,
  input  opKindT               opKind,
  input  olT                   ol,
  input  instrT                instr,
  input  logic [dataWidth-1:0] tvec,
  input  logic [dataWidth-1:0] a,
  input  logic [addrWidth-1:0] nextPc,
  input  imT                   im,
  input  logic [dataWidth-1:0] waitCtr,
  output logic [dataWidth-1:0] calcBus,
  output logic                 rexTaken,
  output logic                 calcValidOut,
  output opKindT               opKindOut
);

  // Poison is built a whole nibble at a time and trimmed
  localparam int nibbleCount = (dataWidth + 3) / 4;

  logic [nibbleCount*4-1:0] poisonFill;
  logic [dataWidth-1:0] poison;
  logic [dataWidth-1:0] nextPcExt;
  logic [dataWidth-1:0] brkValue;
  logic [dataWidth-1:0] retTarget;
  imT rexLimit;

  assign poisonFill = {nibbleCount{poisonNibble}};
  assign poison = poisonFill[dataWidth-1:0];

  // Address is narrower or equal, zero fill above it
  assign nextPcExt = dataWidth'(nextPc);

  // Low byte of a merged with the cause field
  assign brkValue = dataWidth'(a[causeWidth-1:0] | instr[immLsb +: causeWidth]);

  // Unsigned immediate offset from a
  assign retTarget = a + dataWidth'(instr[immLsb +: immWidth]);

  // Inverse of level followed by two zero bits, 4-bit compare
  assign rexLimit = ~{ol, 2'b00};

  // ====================================================================
  // Result select
  // ====================================================================
  always_comb
  begin
    rexTaken = 1'b0;
    case (opKind)
      kBrk: calcBus = brkValue;
      kLink: calcBus = nextPcExt;
      kRet: calcBus = retTarget;
      kRex:
        case (ol)
          olUser: calcBus = poison;
          olMachine, olSuper, olHyper:
          begin
            // Trap vector when the mask sits below the level limit
            rexTaken = im < rexLimit;
            calcBus = rexTaken ? tvec : nextPcExt;
          end
          default: calcBus = poison;
        endcase
      kWait: calcBus = dataWidth'(waitCtr == dataWidth'(1));
      default: calcBus = poison;
    endcase
  end

  // Qualifiers travel alongside the bus
  assign calcValidOut = calcValid;
  assign opKindOut = opKind;

endmodule

//--- design/fcuResult.sv
/*
  Result stage of the flow-control unit
  Registers the result word
  Raises done, redirect and fault pulses
*/
`timescale 1ns/1ns

module fcuResult
  import fcuIsaPkg::*;
  import fcuTypesPkg::*;
#(
  parameter int dataWidth = 80
)
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 calcValid,
  input  opKindT               opKind,
  input  logic [dataWidth-1:0] calcBus,
  input  logic                 rexTaken,
  input  olT                   level,
  output logic [dataWidth-1:0] result,
  output logic                 done,
  output logic                 redirect,
  output logic                 fault
);

  logic redirectNext;
  logic faultNext;

  // PC changes for RET and for a REX that took the vector
  assign redirectNext = (opKind == kRet) || ((opKind == kRex) && rexTaken);

  // Illegal encodings and REX from user level both fault
  assign faultNext = (opKind == kIllegal) || ((opKind == kRex) && (level == olUser));

  // ====================================================================
  // Output registers
  // ====================================================================
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      result <= '0;
      done <= 1'b0;
      redirect <= 1'b0;
      fault <= 1'b0;
    end
    else
    begin
      // Pulses last a single cycle
      done <= calcValid;
      redirect <= calcValid && redirectNext;
      fault <= calcValid && faultNext;
      // Result holds until the next valid op
      if (calcValid)
        result <= calcBus;
    end
  end

endmodule

//--- design/fcuTop.sv
/*
  Top level of the flow-control unit
  Issue stage, calculator and result stage
  Sets the data and address widths
*/
`timescale 1ns/1ns

module fcuTop
  import fcuTypesPkg::*;
#(
  parameter int dataWidth = 80,
  parameter int addrWidth = 80
)
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 issue,
  input  olT                   ol,
  input  instrT                instr,
  input  logic [dataWidth-1:0] tvec,
  input  logic [dataWidth-1:0] a,
  input  logic [addrWidth-1:0] nextPc,
  input  imT                   im,
  input  logic [dataWidth-1:0] waitCtr,
  output logic [dataWidth-1:0] result,
  output logic                 done,
  output logic                 redirect,
  output logic                 fault
);

  // Issue stage outputs
  logic calcValid;
  opKindT opKind;
  olT olQ;
  instrT instrQ;
  logic [dataWidth-1:0] tvecQ;
  logic [dataWidth-1:0] aQ;
  logic [addrWidth-1:0] nextPcQ;
  imT imQ;
  logic [dataWidth-1:0] waitCtrQ;

  // Calculator outputs
  logic [dataWidth-1:0] calcBus;
  logic rexTaken;
  logic calcValidOut;
  opKindT opKindOut;

  fcuIssue #(
    .dataWidth(dataWidth),
    .addrWidth(addrWidth)
  ) issueStage (
    .clk(clk), .rstN(rstN), .issue(issue),
    .ol(ol), .instr(instr), .tvec(tvec), .a(a), .nextPc(nextPc), .im(im),
    .waitCtr(waitCtr), .calcValid(calcValid), .opKind(opKind), .olQ(olQ),
    .instrQ(instrQ), .tvecQ(tvecQ), .aQ(aQ), .nextPcQ(nextPcQ), .imQ(imQ),
    .waitCtrQ(waitCtrQ)
  );

  fcuCalc #(
    .dataWidth(dataWidth),
    .addrWidth(addrWidth)
  ) calc (
    .calcValid(calcValid), .opKind(opKind), .ol(olQ), .instr(instrQ),
    .tvec(tvecQ), .a(aQ), .nextPc(nextPcQ), .im(imQ), .waitCtr(waitCtrQ),
    .calcBus(calcBus), .rexTaken(rexTaken), .calcValidOut(calcValidOut),
    .opKindOut(opKindOut)
  );

  // Level comes from the captured operands, not the live input
  fcuResult #(
    .dataWidth(dataWidth)
  ) resultStage (
    .clk(clk), .rstN(rstN), .calcValid(calcValidOut), .opKind(opKindOut),
    .calcBus(calcBus), .rexTaken(rexTaken), .level(olQ), .result(result),
    .done(done), .redirect(redirect), .fault(fault)
  );

endmodule

//--- testbench/fcuTb_sva.sv
/*
  Bound assertions on the flow-control unit outputs
  One done per issue two edges after it
  Redirect and fault only alongside done
*/
`timescale 1ns/1ns

module outputPulseChecks
(
  input logic clk,
  input logic rstN,
  input logic issue,
  input logic done,
  input logic redirect,
  input logic fault
);

  // Every issue completes two rising edges later
  doneAfterIssue: assert property (@(posedge clk) disable iff (!rstN)
    $past(issue, 2) |-> done)
    else $error("done missing two cycles after issue");

  // One done cycle per operation, wider only for back-to-back issues
  doneWidth: assert property (@(posedge clk) disable iff (!rstN)
    done |-> $past(issue, 2))
    else $error("done high without an issue two cycles before");

  sideWithDone: assert property (@(posedge clk) disable iff (!rstN)
    (redirect || fault) |-> done)
    else $error("redirect or fault high without done");

  // A faulting op never redirects
  exclusiveSide: assert property (@(posedge clk) disable iff (!rstN)
    !(redirect && fault))
    else $error("redirect and fault high together");

endmodule

bind fcuTop outputPulseChecks pulseChecks (
  .clk(clk), .rstN(rstN), .issue(issue),
  .done(done), .redirect(redirect), .fault(fault)
);

//--- testbench/fcuTb.sv
/*
  Testbench for the flow-control unit
  Trace-driven stimulus with random idle gaps between issues
  Result, redirect, fault and done timing checks
*/
`timescale 1ns/1ns

module fcuTb
  import fcuTypesPkg::*;
();

  localparam int dataWidth = 80;
  localparam int addrWidth = 80;
  // Cycles allowed for the last operations to drain
  localparam int drainLimit = 20;

  logic clk;
  logic rstN;
  logic issue;
  olT ol;
  instrT instr;
  logic [dataWidth-1:0] tvec;
  logic [dataWidth-1:0] a;
  logic [addrWidth-1:0] nextPc;
  imT im;
  logic [dataWidth-1:0] waitCtr;
  logic [dataWidth-1:0] result;
  logic done;
  logic redirect;
  logic fault;

  // Current trace row
  olT rowOl;
  instrT rowInstr;
  logic [dataWidth-1:0] rowTvec;
  logic [dataWidth-1:0] rowA;
  logic [addrWidth-1:0] rowNextPc;
  imT rowIm;
  logic [dataWidth-1:0] rowWaitCtr;
  logic [dataWidth-1:0] rowResult;
  logic rowRedirect;
  logic rowFault;

  // Operations in flight, oldest first
  logic [dataWidth-1:0] expResultQ[$];
  logic expRedirectQ[$];
  logic expFaultQ[$];
  int dueQ[$];

  int cycle;
  int valueErrors;
  int otherErrors;
  logic [31:0] lfsrState;

  always #5 clk = ~clk;

  fcuTop #(
    .dataWidth(dataWidth),
    .addrWidth(addrWidth)
  ) UUT (
    .clk(clk), .rstN(rstN), .issue(issue), .ol(ol), .instr(instr), .tvec(tvec),
    .a(a), .nextPc(nextPc), .im(im), .waitCtr(waitCtr), .result(result),
    .done(done), .redirect(redirect), .fault(fault)
  );

  task automatic checkValue(input string name, input logic [dataWidth-1:0] actual,
                            input logic [dataWidth-1:0] expected);
    if (actual !== expected)
    begin
      $display("** Error: %s is %h, expected %h (cycle %0d)", name, actual, expected, cycle);
      valueErrors++;
    end
  endtask

  // ====================================================================
  // Random gaps, x^32 + x^22 + x^2 + x + 1
  // ====================================================================
  function automatic logic nextLfsrBit();
    logic feedback;
    feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], feedback};
    return feedback;
  endfunction

  // Zero to three idle cycles, zero gives back-to-back issues
  function automatic int drawGap();
    int gap;
    gap = 0;
    for (int i = 0; i < 2; i++)
      gap = (gap << 1) | int'(nextLfsrBit());
    return gap;
  endfunction

  // Falling edge, then look at what the DUT produced
  task automatic stepCycle();
    logic [dataWidth-1:0] expResult;
    logic expRedirect;
    logic expFault;
    int due;
    @(negedge clk);
    cycle++;
    if ((redirect || fault) && !done)
    begin
      $display("Redirect or fault pulsed without done at cycle %0d", cycle);
      otherErrors++;
    end
    if (done)
    begin
      if (dueQ.size() == 0)
      begin
        $display("Done pulsed at cycle %0d with no operation in flight", cycle);
        otherErrors++;
      end
      else
      begin
        expResult = expResultQ.pop_front();
        expRedirect = expRedirectQ.pop_front();
        expFault = expFaultQ.pop_front();
        due = dueQ.pop_front();
        if (due != cycle)
        begin
          $display("Done came at cycle %0d but was due at cycle %0d", cycle, due);
          otherErrors++;
        end
        checkValue("result", result, expResult);
        checkValue("redirect", dataWidth'(redirect), dataWidth'(expRedirect));
        checkValue("fault", dataWidth'(fault), dataWidth'(expFault));
      end
    end
  endtask

  // Idle gap, then one issue on a falling edge
  task automatic issueRow();
    int gap;
    gap = drawGap();
    repeat (gap)
    begin
      stepCycle();
      issue = 1'b0;
    end
    stepCycle();
    ol = rowOl;
    instr = rowInstr;
    tvec = rowTvec;
    a = rowA;
    nextPc = rowNextPc;
    im = rowIm;
    waitCtr = rowWaitCtr;
    issue = 1'b1;
    // Two rising edges from issue to done
    expResultQ.push_back(rowResult);
    expRedirectQ.push_back(rowRedirect);
    expFaultQ.push_back(rowFault);
    dueQ.push_back(cycle + 2);
  endtask

  initial
  begin
    int fd;
    int fields;
    int rows;
    int waited;
    logic stopRead;
    string line;
    clk = 1'b0;
    rstN = 1'b0;
    issue = 1'b0;
    ol = '0;
    instr = '0;
    tvec = '0;
    a = '0;
    nextPc = '0;
    im = '0;
    waitCtr = '0;
    cycle = 0;
    valueErrors = 0;
    otherErrors = 0;
    rows = 0;
    lfsrState = 32'h549e;

    // Result must sit at zero through reset
    repeat (10)
    begin
      stepCycle();
      checkValue("result", result, '0);
    end
    rstN = 1'b1;

    fd = $fopen("testbench/fcuTrace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file testbench/fcuTrace.txt");
      otherErrors++;
    end
    else
    begin
      stopRead = 1'b0;
      while (!stopRead && !$feof(fd))
      begin
        fields = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h\n", rowOl, rowInstr, rowTvec,
                         rowA, rowNextPc, rowIm, rowWaitCtr, rowResult, rowRedirect, rowFault);
        if (fields == 10)
        begin
          issueRow();
          rows++;
        end
        else
        begin
          // Comment lines fail the scan and are skipped whole
          if (fields > 0)
          begin
            $display("Trace row after row %0d has only %0d fields", rows, fields);
            otherErrors++;
          end
          if ($fgets(line, fd) == 0)
            stopRead = 1'b1;
        end
      end
      $fclose(fd);
      if (rows == 0)
      begin
        $display("The trace file holds no stimulus rows");
        otherErrors++;
      end
    end

    stepCycle();
    issue = 1'b0;

    // ==================================================================
    // Drain
    // ==================================================================
    waited = 0;
    while (dueQ.size() > 0 && waited < drainLimit)
    begin
      stepCycle();
      waited++;
    end
    if (dueQ.size() > 0)
    begin
      $display("Timed out waiting for %0d done pulses", dueQ.size());
      otherErrors++;
    end
    // Quiet tail, no stray pulses
    repeat (3)
      stepCycle();

    $display("%0d rows, %0d value errors, %0d other errors", rows, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- testbench/fcuTrace.txt
# ol instr tvec a nextPc im waitCtr | expected: result redirect fault
# All fields hex; one issued operation per row, poison is the nibble C repeated
0 0016800000 0 ffff0000000000000123 0 0 0 7b 0 0
2 ff20000000 0 ab01 0 0 0 81 0 0
0 0000000040 0 5 123456789abcdef00000 0 0 123456789abcdef00000 0 0
1 0000000080 0 0 4000 0 0 4000 0 0
0 ffffc000c0 0 1 0 0 0 40000 1 0
3 00004000c0 0 0000ffffffffffffffff 0 0 0 00010000000000000000 1 0
1 48d14000c0 0 1000 0 0 0 13345 1 0
0 0000000100 aaaabbbbccccddddeeee 0 2000 e 0 aaaabbbbccccddddeeee 1 0
0 0000000100 aaaabbbbccccddddeeee 0 2000 f 0 2000 0 0
1 0000000100 1111 0 3000 a 0 1111 1 0
1 0000000100 1111 0 3000 b 0 3000 0 0
2 0000000100 7777 0 5000 6 0 7777 1 0
2 0000000100 7777 0 5000 7 0 5000 0 0
3 0000000100 5555 0 6000 0 0 cccccccccccccccccccc 0 1
0 0004800140 0 0 0 0 1 1 0 0
0 0004800140 0 0 0 0 2 0 0 0
1 0004800140 0 0 0 0 10000000000000000001 0 0 0
0 0004000140 0 0 0 0 0 cccccccccccccccccccc 0 1
0 0000000180 0 0 0 0 0 cccccccccccccccccccc 0 1
2 00000003c0 0 0 0 0 0 cccccccccccccccccccc 0 1
1 0000000140 0 0 0 0 0 cccccccccccccccccccc 0 1

//--- vlog.f
design/fcuIsaPkg.sv
design/fcuTypesPkg.sv
design/fcuIssue.sv
design/fcuCalc.sv
design/fcuResult.sv
design/fcuTop.sv
testbench/fcuTb_sva.sv
testbench/fcuTb.sv

//--- Makefile
# Verilator build and run of the flow-control unit testbench

VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = fcuTb
FILELIST = vlog.f
OBJDIR = obj_dir
LOG = sim.log
# Keep running past assertion errors so the testbench reaches its verdict
RUNFLAGS = +verilator+error+limit+100

SOURCES = $(shell cat $(FILELIST))
SIM = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUNFLAGS) 2>&1 | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
